//--- memPostCfgPkg.sv
`default_nettype none

package memPostCfgPkg;

  ////////////////////////////////////////////////////////////
  // Widths with a meaning
  ////////////////////////////////////////////////////////////
  typedef logic [3:0]  tCfgAddr;  // Register index
  typedef logic [31:0] tCfgData;  // Config bus word
  typedef logic [31:0] tAddr;     // Host byte address
  typedef logic [7:0]  tWordCnt;  // Count of 64-bit words

  // Register bank to scheduler, 73 bits
  typedef struct packed {
    logic    enable;
    tAddr    base0;
    tAddr    base1;
    tWordCnt wordsPerTransfer;
  } tCfg;

  // Register map
  localparam tCfgAddr cRegCtrl   = 4'd0;
  localparam tCfgAddr cRegStatus = 4'd1;
  localparam tCfgAddr cRegBase0  = 4'd2;
  localparam tCfgAddr cRegBase1  = 4'd3;
  localparam tCfgAddr cRegWords  = 4'd4;

  localparam tWordCnt cResetWords = 8'd8;  // 8 words = 64 bytes
  localparam int      cAlignBits  = 6;     // 64-byte aligned bases

endpackage

`default_nettype wire

//--- memPostTlpPkg.sv
`default_nettype none

package memPostTlpPkg;

  ////////////////////////////////////////////////////////////
  // Packet and credit widths
  ////////////////////////////////////////////////////////////
  typedef logic [63:0] tLine;          // One transmit line
  typedef logic [7:0]  tPhCred;        // Posted header credits
  typedef logic [11:0] tPdCred;        // Posted data credits, 16 bytes each
  typedef logic [11:0] tPayloadBytes;
  typedef logic [15:0] tReqId;         // Bus, device, function
  typedef logic [9:0]  tDwLen;

  localparam logic [7:0] cFmtTypeMemWr = 8'h40;  // 3DW header with data
  localparam logic [7:0] cFirstBe      = 8'hFF;  // Last and first BE, all lanes

  localparam int cLineFifoDepth = 4;
  localparam int cLineBytes     = 8;

  // One memory write packet, 52 bits
  typedef struct packed {
    memPostCfgPkg::tAddr    addr;
    memPostCfgPkg::tWordCnt words;
    tPdCred                 pdInc;
  } tPostDesc;

  // Transmit stream line, 66 bits
  typedef struct packed {
    logic sop;
    logic eop;
    tLine data;
  } tTxLine;

endpackage

`default_nettype wire

//--- memPostCfgRegs.sv
`timescale 1ns/10ps
`default_nettype none

module memPostCfgRegs (
  input  wire                     i_CfgClk,
  input  wire                     i_ARst,
  input  wire                     i_CfgCyc,
  input  wire                     i_CfgStb,
  input  wire                     i_CfgWnR,
  input  memPostCfgPkg::tCfgAddr  i_CfgAddr,
  input  memPostCfgPkg::tCfgData  i_CfgWrData,
  output memPostCfgPkg::tCfgData  o_CfgRdData,
  output logic                    o_CfgAck,
  input  wire                     i_InvalidSetting,
  input  wire                     i_Busy,
  output memPostCfgPkg::tCfg      o_Cfg
);

  memPostCfgPkg::tCfg     r_Cfg;
  memPostCfgPkg::tCfgData w_Status;
  logic                   w_Write;

  assign w_Write  = i_CfgCyc & i_CfgStb & i_CfgWnR;
  assign w_Status = {i_InvalidSetting, 30'h0, i_Busy};

  ////////////////////////////////////////////////////////////
  // Register writes and acknowledge
  ////////////////////////////////////////////////////////////
  always_ff @(posedge i_CfgClk or posedge i_ARst)
  begin
    if (i_ARst)
    begin
      r_Cfg.enable           <= 1'b0;
      r_Cfg.base0            <= '0;
      r_Cfg.base1            <= '0;
      r_Cfg.wordsPerTransfer <= memPostCfgPkg::cResetWords;
      o_CfgAck               <= 1'b0;
    end
    else
    begin
      if (w_Write)
      begin
        case (i_CfgAddr)
          memPostCfgPkg::cRegCtrl:  r_Cfg.enable           <= i_CfgWrData[0];
          memPostCfgPkg::cRegBase0: r_Cfg.base0            <= i_CfgWrData;
          memPostCfgPkg::cRegBase1: r_Cfg.base1            <= i_CfgWrData;
          memPostCfgPkg::cRegWords: r_Cfg.wordsPerTransfer <= i_CfgWrData[7:0];
          default: ;  // Status is read only
        endcase
      end
      o_CfgAck <= i_CfgCyc & i_CfgStb & ~o_CfgAck;  // One cycle, even if strobe held
    end
  end

  // Readback mux
  always_comb
  begin
    case (i_CfgAddr)
      memPostCfgPkg::cRegCtrl:   o_CfgRdData = {31'h0, r_Cfg.enable};
      memPostCfgPkg::cRegStatus: o_CfgRdData = w_Status;
      memPostCfgPkg::cRegBase0:  o_CfgRdData = r_Cfg.base0;
      memPostCfgPkg::cRegBase1:  o_CfgRdData = r_Cfg.base1;
      memPostCfgPkg::cRegWords:  o_CfgRdData = {24'h0, r_Cfg.wordsPerTransfer};
      default:                   o_CfgRdData = '0;
    endcase
  end

  assign o_Cfg = r_Cfg;

endmodule

`default_nettype wire

//--- memPostScheduler.sv
`timescale 1ns/10ps
`default_nettype none

module memPostScheduler (
  input  wire                           i_CfgClk,
  input  wire                           i_ARst,
  input  memPostCfgPkg::tCfg            i_Cfg,
  input  wire                           i_Start,
  input  wire  [15:0]                   i_UsedWords,
  input  memPostTlpPkg::tPayloadBytes   i_MaxPload,
  input  memPostTlpPkg::tPhCred         i_CredLimPh,
  input  memPostTlpPkg::tPhCred         i_CredConPh,
  input  memPostTlpPkg::tPdCred         i_CredLimPd,
  input  memPostTlpPkg::tPdCred         i_CredConPd,
  input  wire                           i_InfinitePh,
  input  wire                           i_InfinitePd,
  output memPostTlpPkg::tPostDesc       o_Desc,
  output logic                          o_DescValid,
  input  wire                           i_DescReady,
  input  wire                           i_Done,
  output logic                          o_InvalidSetting,
  output logic                          o_Busy
);

  typedef enum logic [1:0] {sIdle, sCredCheck, sOffer, sWaitDone} tState;

  tState                   r_State;
  logic                    r_Enable;
  logic                    r_BufPtr;    // Base used by the next start
  memPostCfgPkg::tAddr     r_PostAddr;
  memPostCfgPkg::tWordCnt  r_Words;
  memPostTlpPkg::tPhCred   r_RqdPh;     // Cumulative credits this packet needs
  memPostTlpPkg::tPdCred   r_RqdPd;
  memPostTlpPkg::tPdCred   r_PdInc;
  memPostTlpPkg::tPdCred   w_PdInc;
  memPostTlpPkg::tPostDesc r_Desc;
  logic                    w_DataReady;
  logic                    w_PhEnough;
  logic                    w_PdEnough;

  ////////////////////////////////////////////////////////////
  // Setting guard and readiness
  ////////////////////////////////////////////////////////////
  assign o_InvalidSetting =
    (i_Cfg.base0[memPostCfgPkg::cAlignBits-1:0] != '0) |
    (i_Cfg.base1[memPostCfgPkg::cAlignBits-1:0] != '0) |
    ({1'b0, i_Cfg.wordsPerTransfer, 3'b000} > i_MaxPload);

  assign w_DataReady = i_UsedWords >= {8'h00, i_Cfg.wordsPerTransfer};

  // ceil(words * 8 / 16)
  assign w_PdInc = ({4'h0, i_Cfg.wordsPerTransfer} + 12'd1) >> 1;

  // Modular distance to the limit, below half range means enough
  assign w_PhEnough = ((i_CredLimPh - r_RqdPh) < 8'h80) | i_InfinitePh;
  assign w_PdEnough = ((i_CredLimPd - r_RqdPd) < 12'h800) | i_InfinitePd;

  always_ff @(posedge i_CfgClk or posedge i_ARst)
  begin
    if (i_ARst)
    begin
      r_State    <= sIdle;
      r_Enable   <= 1'b0;
      r_BufPtr   <= 1'b0;
      r_PostAddr <= '0;
      r_Words    <= '0;
      r_RqdPh    <= '0;
      r_RqdPd    <= '0;
      r_PdInc    <= '0;
    end
    else
    begin
      case (r_State)
        sIdle:
        begin
          if (r_Enable & ~o_InvalidSetting & w_DataReady)
          begin
            r_RqdPh <= i_CredConPh + 8'd1;  // One header per packet
            r_RqdPd <= i_CredConPd + w_PdInc;
            r_PdInc <= w_PdInc;
            r_Words <= i_Cfg.wordsPerTransfer;
            r_State <= sCredCheck;
          end
        end
        sCredCheck:
          if (w_PhEnough & w_PdEnough)
            r_State <= sOffer;
        sOffer:
          if (i_DescReady)
            r_State <= sWaitDone;
        sWaitDone:
          if (i_Done)
          begin
            r_PostAddr <= r_PostAddr + {21'h0, r_Words, 3'b000};
            r_State    <= sIdle;
          end
        default: r_State <= sIdle;
      endcase

      // New buffer overrides any pending advance
      if (i_Start)
      begin
        r_Enable   <= i_Cfg.enable;
        r_BufPtr   <= ~r_BufPtr;
        r_PostAddr <= r_BufPtr ? i_Cfg.base1 : i_Cfg.base0;
      end
    end
  end

  // Descriptor frozen while offered
  always_ff @(posedge i_CfgClk)
  begin
    if (r_State == sCredCheck)
    begin
      r_Desc.addr  <= r_PostAddr;
      r_Desc.words <= r_Words;
      r_Desc.pdInc <= r_PdInc;
    end
  end

  assign o_Desc      = r_Desc;
  assign o_DescValid = r_State == sOffer;
  assign o_Busy      = r_State != sIdle;

endmodule

`default_nettype wire

//--- memPostLineFifo.sv
`timescale 1ns/10ps
`default_nettype none

module memPostLineFifo (
  input  wire                     i_CfgClk,
  input  wire                     i_ARst,
  input  wire                     i_FetchStart,
  input  memPostCfgPkg::tWordCnt  i_FetchWords,
  output logic                    o_LclReq,
  input  wire                     i_LclDv,
  input  memPostTlpPkg::tLine     i_LclData,
  input  wire                     i_LclEmpty,
  input  wire                     i_Pop,
  output memPostTlpPkg::tLine     o_Line,
  output logic                    o_Empty
);

  localparam int cPtrW = $clog2(memPostTlpPkg::cLineFifoDepth);
  localparam int cCntW = cPtrW + 1;

  memPostTlpPkg::tLine    r_Mem [memPostTlpPkg::cLineFifoDepth];
  logic [cPtrW-1:0]       r_WrPtr;
  logic [cPtrW-1:0]       r_RdPtr;
  logic [cCntW-1:0]       r_Count;
  logic                   r_ReqD1;   // Request whose data lands this cycle
  memPostCfgPkg::tWordCnt r_Budget;  // Lines still to fetch
  logic [cCntW:0]         w_Used;

  // Entries plus in-flight reads, anything below depth is a free credit
  assign w_Used   = {1'b0, r_Count} + {{cCntW{1'b0}}, r_ReqD1};
  assign o_LclReq = (r_Budget != '0) & ~i_LclEmpty &
                    (w_Used < (cCntW + 1)'(memPostTlpPkg::cLineFifoDepth));

  always_ff @(posedge i_CfgClk or posedge i_ARst)
  begin
    if (i_ARst)
    begin
      r_WrPtr  <= '0;
      r_RdPtr  <= '0;
      r_Count  <= '0;
      r_ReqD1  <= 1'b0;
      r_Budget <= '0;
    end
    else
    begin
      r_ReqD1 <= o_LclReq;
      if (i_FetchStart)
        r_Budget <= i_FetchWords;
      else if (o_LclReq)
        r_Budget <= r_Budget - 8'd1;
      if (i_LclDv)
        r_WrPtr <= r_WrPtr + 1'b1;
      if (i_Pop)
        r_RdPtr <= r_RdPtr + 1'b1;
      case ({i_LclDv, i_Pop})
        2'b10:   r_Count <= r_Count + 1'b1;
        2'b01:   r_Count <= r_Count - 1'b1;
        default: ;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge i_CfgClk)
    if (i_LclDv)
      r_Mem[r_WrPtr] <= i_LclData;

  assign o_Line  = r_Mem[r_RdPtr];
  assign o_Empty = r_Count == '0;

endmodule

`default_nettype wire

//--- memPostFramer.sv
`timescale 1ns/10ps
`default_nettype none

module memPostFramer (
  input  wire                      i_CfgClk,
  input  wire                      i_ARst,
  input  memPostTlpPkg::tPostDesc  i_Desc,
  input  wire                      i_DescValid,
  output logic                     o_DescReady,
  output logic                     o_Done,
  input  memPostTlpPkg::tReqId     i_ReqId,
  output logic                     o_FetchStart,
  output memPostCfgPkg::tWordCnt   o_FetchWords,
  output logic                     o_Pop,
  input  memPostTlpPkg::tLine      i_Line,
  input  wire                      i_FifoEmpty,
  output memPostTlpPkg::tTxLine    o_TxLine,
  output logic                     o_TxValid,
  input  wire                      i_TxReady,
  output logic                     o_UpdPh,
  output logic                     o_UpdPd,
  output memPostTlpPkg::tPdCred    o_IncPd
);

  typedef enum logic [1:0] {sIdle, sHdr0, sHdr1, sPayload} tState;

  tState                   r_State;  // Which line sits in the output register
  memPostTlpPkg::tPostDesc r_Desc;
  memPostTlpPkg::tTxLine   r_TxLine;
  logic                    r_TxValid;
  logic [7:0]              r_Tag;
  memPostCfgPkg::tWordCnt  r_Left;   // Payload lines not yet loaded
  memPostTlpPkg::tDwLen    w_DwLen;
  memPostTlpPkg::tLine     w_Hdr0;
  memPostTlpPkg::tLine     w_Hdr1;
  logic                    w_DescXfer;
  logic                    w_Adv;
  logic                    w_Xfer;

  ////////////////////////////////////////////////////////////
  // Header lines
  ////////////////////////////////////////////////////////////
  assign w_DwLen = {1'b0, i_Desc.words, 1'b0};  // Two dwords per word
  assign w_Hdr0  = {i_ReqId, r_Tag, memPostTlpPkg::cFirstBe,
                    memPostTlpPkg::cFmtTypeMemWr, 8'h00, 6'h00, w_DwLen};
  assign w_Hdr1  = {32'h0, r_Desc.addr};

  assign o_DescReady = r_State == sIdle;
  assign w_DescXfer  = i_DescValid & o_DescReady;
  assign w_Adv       = ~r_TxValid | i_TxReady;  // Output slot free next cycle
  assign w_Xfer      = r_TxValid & i_TxReady;

  assign o_Pop = ((r_State == sHdr1) | (r_State == sPayload)) & w_Adv &
                 (r_Left != '0) & ~i_FifoEmpty;

  always_ff @(posedge i_CfgClk or posedge i_ARst)
  begin
    if (i_ARst)
    begin
      r_State   <= sIdle;
      r_TxValid <= 1'b0;
      r_Tag     <= '0;
      r_Left    <= '0;
    end
    else
    begin
      case (r_State)
        sIdle:
          if (w_DescXfer)
          begin
            r_TxValid <= 1'b1;
            r_Left    <= i_Desc.words;
            r_State   <= sHdr0;
          end
        sHdr0:
          if (i_TxReady)
            r_State <= sHdr1;
        sHdr1, sPayload:
        begin
          if (o_Pop)
          begin
            r_TxValid <= 1'b1;
            r_Left    <= r_Left - 8'd1;
          end
          else if (w_Xfer)
            r_TxValid <= 1'b0;  // Bubble while FIFO is empty

          if (r_State == sHdr1 && i_TxReady)
            r_State <= sPayload;
          else if (r_State == sPayload && w_Xfer && r_TxLine.eop)
          begin
            r_State <= sIdle;
            r_Tag   <= r_Tag + 8'd1;
          end
        end
        default: r_State <= sIdle;
      endcase
    end
  end

  // Line and descriptor payload, held while stalled
  always_ff @(posedge i_CfgClk)
  begin
    if (w_DescXfer)
    begin
      r_Desc   <= i_Desc;
      r_TxLine <= '{sop: 1'b1, eop: 1'b0, data: w_Hdr0};
    end
    else if (r_State == sHdr0 && i_TxReady)
      r_TxLine <= '{sop: 1'b0, eop: 1'b0, data: w_Hdr1};
    else if (o_Pop)
      r_TxLine <= '{sop: 1'b0, eop: (r_Left == 8'd1), data: i_Line};
  end

  assign o_TxLine     = r_TxLine;
  assign o_TxValid    = r_TxValid;
  assign o_Done       = w_Xfer & r_TxLine.eop;
  assign o_FetchStart = w_DescXfer;
  assign o_FetchWords = i_Desc.words;
  assign o_UpdPh      = w_Xfer & r_TxLine.sop;
  assign o_UpdPd      = w_Xfer & r_TxLine.eop;
  assign o_IncPd      = r_Desc.pdInc;

endmodule

`default_nettype wire

//--- memPostTop.sv
`timescale 1ns/10ps
`default_nettype none

module memPostTop (
  input  wire                          i_CfgClk,
  input  wire                          i_ARst,
  // Configuration bus
  input  wire                          i_CfgCyc,
  input  wire                          i_CfgStb,
  input  wire                          i_CfgWnR,
  input  memPostCfgPkg::tCfgAddr       i_CfgAddr,
  input  memPostCfgPkg::tCfgData       i_CfgWrData,
  output memPostCfgPkg::tCfgData       o_CfgRdData,
  output logic                         o_CfgAck,
  // Local source
  input  wire                          i_Start,
  input  wire  [15:0]                  i_UsedWords,
  output logic                         o_LclReq,
  input  wire                          i_LclDv,
  input  memPostTlpPkg::tLine          i_LclData,
  input  wire                          i_LclEmpty,
  // PCIe side
  input  memPostTlpPkg::tReqId         i_ReqId,
  input  memPostTlpPkg::tPayloadBytes  i_MaxPload,
  input  memPostTlpPkg::tPhCred        i_CredLimPh,
  input  memPostTlpPkg::tPhCred        i_CredConPh,
  input  memPostTlpPkg::tPdCred        i_CredLimPd,
  input  memPostTlpPkg::tPdCred        i_CredConPd,
  input  wire                          i_InfinitePh,
  input  wire                          i_InfinitePd,
  output memPostTlpPkg::tTxLine        o_TxLine,
  output logic                         o_TxValid,
  input  wire                          i_TxReady,
  output logic                         o_UpdPh,
  output logic                         o_UpdPd,
  output memPostTlpPkg::tPhCred        o_IncPh,
  output memPostTlpPkg::tPdCred        o_IncPd
);

  memPostCfgPkg::tCfg      w_Cfg;
  memPostTlpPkg::tPostDesc w_Desc;
  memPostCfgPkg::tWordCnt  w_FetchWords;
  memPostTlpPkg::tLine     w_FifoLine;
  logic                    w_InvalidSetting;
  logic                    w_Busy;
  logic                    w_DescValid;
  logic                    w_DescReady;
  logic                    w_Done;
  logic                    w_FetchStart;
  logic                    w_Pop;
  logic                    w_FifoEmpty;

  assign o_IncPh = 8'd1;  // One header per packet

  memPostCfgRegs uCfgRegs (
    .i_CfgClk, .i_ARst, .i_CfgCyc, .i_CfgStb, .i_CfgWnR, .i_CfgAddr, .i_CfgWrData,
    .o_CfgRdData, .o_CfgAck,
    .i_InvalidSetting (w_InvalidSetting),
    .i_Busy           (w_Busy),
    .o_Cfg            (w_Cfg)
  );

  memPostScheduler uScheduler (
    .i_CfgClk, .i_ARst,
    .i_Cfg (w_Cfg),
    .i_Start, .i_UsedWords, .i_MaxPload,
    .i_CredLimPh, .i_CredConPh, .i_CredLimPd, .i_CredConPd, .i_InfinitePh, .i_InfinitePd,
    .o_Desc           (w_Desc),
    .o_DescValid      (w_DescValid),
    .i_DescReady      (w_DescReady),
    .i_Done           (w_Done),
    .o_InvalidSetting (w_InvalidSetting),
    .o_Busy           (w_Busy)
  );

  memPostLineFifo uLineFifo (
    .i_CfgClk, .i_ARst,
    .i_FetchStart (w_FetchStart),
    .i_FetchWords (w_FetchWords),
    .o_LclReq, .i_LclDv, .i_LclData, .i_LclEmpty,
    .i_Pop        (w_Pop),
    .o_Line       (w_FifoLine),
    .o_Empty      (w_FifoEmpty)
  );

  memPostFramer uFramer (
    .i_CfgClk, .i_ARst,
    .i_Desc       (w_Desc),
    .i_DescValid  (w_DescValid),
    .o_DescReady  (w_DescReady),
    .o_Done       (w_Done),
    .i_ReqId,
    .o_FetchStart (w_FetchStart),
    .o_FetchWords (w_FetchWords),
    .o_Pop        (w_Pop),
    .i_Line       (w_FifoLine),
    .i_FifoEmpty  (w_FifoEmpty),
    .o_TxLine, .o_TxValid, .i_TxReady, .o_UpdPh, .o_UpdPd, .o_IncPd
  );

endmodule

`default_nettype wire

//--- tbClkGen.sv
`timescale 1ns/10ps
`default_nettype none

module tbClkGen (
  output logic o_CfgClk,
  output logic o_ARst
);

  initial
  begin
    o_CfgClk = 1'b0;
    forever #5 o_CfgClk = ~o_CfgClk;  // 10 ns period
  end

  // Reset held for the first 10 cycles
  initial
  begin
    o_ARst = 1'b1;
    repeat (10) @(posedge o_CfgClk);
    o_ARst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- tbMemPost_assert.sv
`timescale 1ns/10ps
`default_nettype none

module tbMemPostAssert (
  input wire                    i_CfgClk,
  input wire                    i_ARst,
  input wire                    i_CfgAck,
  input wire                    i_LclReq,
  input wire                    i_LclEmpty,
  input memPostTlpPkg::tTxLine  i_TxLine,
  input wire                    i_TxValid,
  input wire                    i_TxReady,
  input wire                    i_UpdPh,
  input wire                    i_UpdPd
);

  int failCnt = 0;  // Read by the testbench top

  ackPulse: assert property (@(posedge i_CfgClk) disable iff (i_ARst)
    i_CfgAck |=> !i_CfgAck)
  else
  begin
    failCnt++;
    $error("Config ack stayed high for more than one cycle");
  end

  // A line under back-pressure must not move
  stallStable: assert property (@(posedge i_CfgClk) disable iff (i_ARst)
    (i_TxValid && !i_TxReady) |=> (i_TxValid && $stable(i_TxLine)))
  else
  begin
    failCnt++;
    $error("Transmit line changed while stalled");
  end

  noReqWhenEmpty: assert property (@(posedge i_CfgClk) disable iff (i_ARst)
    i_LclEmpty |-> !i_LclReq)
  else
  begin
    failCnt++;
    $error("Local read request while the source is empty");
  end

  resetQuiet: assert property (@(posedge i_CfgClk)
    (i_ARst || $fell(i_ARst)) |-> !(i_TxValid | i_CfgAck | i_LclReq | i_UpdPh | i_UpdPd))
  else
  begin
    failCnt++;
    $error("Output active during or right after reset");
  end

endmodule

bind memPostTop tbMemPostAssert uAssert (
  .i_CfgClk   (i_CfgClk),
  .i_ARst     (i_ARst),
  .i_CfgAck   (o_CfgAck),
  .i_LclReq   (o_LclReq),
  .i_LclEmpty (i_LclEmpty),
  .i_TxLine   (o_TxLine),
  .i_TxValid  (o_TxValid),
  .i_TxReady  (i_TxReady),
  .i_UpdPh    (o_UpdPh),
  .i_UpdPd    (o_UpdPd)
);

`default_nettype wire

//--- tbMemPost.sv
`timescale 1ns/10ps
`default_nettype none

module tbMemPost;

  localparam int          cTimeout = 3000;  // Cycles per wait
  localparam logic [63:0] cSrcBase = 64'hA5A5_0000_0000_0000;
  localparam logic [15:0] cReqId   = 16'h01A0;

  logic w_Clk;
  logic w_ARst;

  // Config bus
  logic                   cfgCyc;
  logic                   cfgStb;
  logic                   cfgWnR;
  memPostCfgPkg::tCfgAddr cfgAddr;
  memPostCfgPkg::tCfgData cfgWrData;
  memPostCfgPkg::tCfgData cfgRdData;
  logic                   cfgAck;

  // Local source model
  logic                start;
  logic                lclReq;
  logic                lclDv     = 1'b0;
  memPostTlpPkg::tLine lclData   = '0;
  logic                lclEmpty  = 1'b1;
  logic [15:0]         usedWords = '0;
  int                  supplied;
  int                  fetched   = 0;
  int                  avail;

  // PCIe side
  memPostTlpPkg::tPayloadBytes maxPload;
  memPostTlpPkg::tPhCred       credLimPh;
  memPostTlpPkg::tPhCred       credConPh;
  memPostTlpPkg::tPdCred       credLimPd;
  memPostTlpPkg::tPdCred       credConPd;
  logic                        infPh;
  logic                        infPd;
  memPostTlpPkg::tTxLine       txLine;
  logic                        txValid;
  logic                        txReady = 1'b1;
  logic                        updPh;
  logic                        updPd;
  memPostTlpPkg::tPhCred       incPh;
  memPostTlpPkg::tPdCred       incPd;

  // Scoreboard
  memPostTlpPkg::tTxLine txQ [$];
  logic [7:0]            expTag;
  int                    expIdx;
  int                    curWords;
  int                    valueErrs;
  int                    otherErrs;
  logic                  aborted;
  logic                  randReady;
  int                    seed = 32'h5eb22d58;
  logic [31:0]           rnd;
  logic                  txXfer;

  tbClkGen uClkGen (.o_CfgClk(w_Clk), .o_ARst(w_ARst));

  memPostTop DUT (
    .i_CfgClk(w_Clk), .i_ARst(w_ARst),
    .i_CfgCyc(cfgCyc), .i_CfgStb(cfgStb), .i_CfgWnR(cfgWnR), .i_CfgAddr(cfgAddr),
    .i_CfgWrData(cfgWrData), .o_CfgRdData(cfgRdData), .o_CfgAck(cfgAck),
    .i_Start(start), .i_UsedWords(usedWords), .o_LclReq(lclReq), .i_LclDv(lclDv),
    .i_LclData(lclData), .i_LclEmpty(lclEmpty),
    .i_ReqId(cReqId), .i_MaxPload(maxPload),
    .i_CredLimPh(credLimPh), .i_CredConPh(credConPh),
    .i_CredLimPd(credLimPd), .i_CredConPd(credConPd),
    .i_InfinitePh(infPh), .i_InfinitePd(infPd),
    .o_TxLine(txLine), .o_TxValid(txValid), .i_TxReady(txReady),
    .o_UpdPh(updPh), .o_UpdPd(updPd), .o_IncPh(incPh), .o_IncPd(incPd)
  );

  ////////////////////////////////////////////////////////////
  // Models and monitor
  ////////////////////////////////////////////////////////////
  always @(posedge w_Clk)
  begin
    avail = supplied - fetched - (lclReq ? 1 : 0);
    lclDv <= lclReq;  // Data one cycle after the request
    if (lclReq)
    begin
      lclData <= cSrcBase + 64'(fetched);
      fetched <= fetched + 1;
    end
    usedWords <= 16'(avail);
    lclEmpty  <= (avail == 0);
  end

  always @(posedge w_Clk)
  begin
    rnd = $random(seed);
    txReady <= randReady ? rnd[0] : 1'b1;
  end

  always @(posedge w_Clk)
  begin
    if (!w_ARst)
    begin
      txXfer = txValid && txReady;
      if (txXfer)
        txQ.push_back(txLine);
      assert (updPh == (txXfer && txLine.sop))
      else
        reportFailure("header credit update does not match a start-of-packet transfer");
      assert (updPd == (txXfer && txLine.eop))
      else
        reportFailure("data credit update does not match an end-of-packet transfer");
      if (updPh)
        checkValue("header credit increment", 1, incPh);
      if (updPd)
        checkValue("data credit increment", pdCredits(curWords), incPd);
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  function automatic int pdCredits(input int words);
    return (words * 8 + 15) / 16;  // 16 bytes per data credit, rounded up
  endfunction

  task automatic reportFailure(input string what);
    otherErrs++;
    $display("ERROR: %s", what);
  endtask

  task automatic checkValue(input string name, input logic [63:0] exp,
                            input logic [63:0] act);
    assert (act === exp)
    else
    begin
      valueErrs++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic busAccess(input logic wnr, input memPostCfgPkg::tCfgAddr addr,
                           input memPostCfgPkg::tCfgData wrData,
                           output memPostCfgPkg::tCfgData rdData);
    int t;
    t = 0;
    rdData = '0;
    @(posedge w_Clk);
    cfgCyc    <= 1'b1;
    cfgStb    <= 1'b1;
    cfgWnR    <= wnr;
    cfgAddr   <= addr;
    cfgWrData <= wrData;
    @(posedge w_Clk);
    while (!cfgAck && t < cTimeout)
    begin
      @(posedge w_Clk);
      t++;
    end
    if (cfgAck)
      rdData = cfgRdData;
    else
    begin
      reportFailure("config bus access was never acknowledged");
      aborted = 1'b1;
    end
    cfgCyc <= 1'b0;
    cfgStb <= 1'b0;
    cfgWnR <= 1'b0;
  endtask

  task automatic writeReg(input memPostCfgPkg::tCfgAddr addr,
                          input memPostCfgPkg::tCfgData data);
    memPostCfgPkg::tCfgData unused;
    busAccess(1'b1, addr, data, unused);
  endtask

  task automatic expectReg(input string name, input memPostCfgPkg::tCfgAddr addr,
                           input memPostCfgPkg::tCfgData exp);
    memPostCfgPkg::tCfgData rd;
    busAccess(1'b0, addr, '0, rd);
    if (!aborted)
      checkValue(name, exp, rd);
  endtask

  task automatic pulseStart();
    @(posedge w_Clk);
    start <= 1'b1;
    @(posedge w_Clk);
    start <= 1'b0;
  endtask

  task automatic supplyWords(input int n);
    @(posedge w_Clk);
    supplied <= supplied + n;
  endtask

  task automatic waitLines(input int n, input string what);
    int t;
    t = 0;
    while (txQ.size() < n && t < cTimeout)
    begin
      @(posedge w_Clk);
      t++;
    end
    if (txQ.size() < n)
    begin
      reportFailure({what, ": packet did not complete in time"});
      aborted = 1'b1;
    end
  endtask

  // Watch a fixed window in which no line may leave
  task automatic expectSilence(input string name, input int cycles);
    int t;
    t = 0;
    while (t < cycles)
    begin
      @(posedge w_Clk);
      t++;
    end
    checkValue({name, " lines sent"}, 0, txQ.size());
  endtask

  task automatic checkPacket(input string name, input logic [31:0] addr, input int words);
    memPostTlpPkg::tTxLine ln;
    logic [63:0]           hdr0;
    int                    i;
    hdr0 = {cReqId, expTag, memPostTlpPkg::cFirstBe, memPostTlpPkg::cFmtTypeMemWr,
            8'h00, 6'h00, 10'(words * 2)};
    waitLines(words + 2, name);
    if (!aborted)
    begin
      for (i = 0; i < words + 2; i++)
      begin
        ln = txQ.pop_front();
        checkValue({name, " sop"}, (i == 0), ln.sop);
        checkValue({name, " eop"}, (i == words + 1), ln.eop);
        if (i == 0)
          checkValue({name, " header 0"}, hdr0, ln.data);
        else if (i == 1)
          checkValue({name, " header 1"}, {32'h0, addr}, ln.data);
        else
        begin
          checkValue({name, " payload"}, cSrcBase + 64'(expIdx), ln.data);
          expIdx++;
        end
      end
      expTag++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial
  begin
    int t;
    int assertFails;
    cfgCyc    = 1'b0;
    cfgStb    = 1'b0;
    cfgWnR    = 1'b0;
    cfgAddr   = '0;
    cfgWrData = '0;
    start     = 1'b0;
    supplied  = 0;
    maxPload  = 12'd256;
    credLimPh = 8'd20;
    credConPh = 8'd0;
    credLimPd = 12'd500;
    credConPd = 12'd0;
    infPh     = 1'b0;
    infPd     = 1'b0;
    randReady = 1'b0;
    aborted   = 1'b0;
    valueErrs = 0;
    otherErrs = 0;
    expTag    = 8'd0;
    expIdx    = 0;
    curWords  = 8;
    t         = 0;

    @(posedge w_Clk);
    while (w_ARst && t < 100)
    begin
      @(posedge w_Clk);
      t++;
    end
    if (w_ARst)
      reportFailure("reset never released");

    // Register readback and setting guard
    expectReg("words after reset", memPostCfgPkg::cRegWords, 32'd8);
    writeReg(memPostCfgPkg::cRegBase0, 32'h1000);
    writeReg(memPostCfgPkg::cRegBase1, 32'h2000);
    curWords = 4;
    writeReg(memPostCfgPkg::cRegWords, 32'd4);
    expectReg("base0 readback", memPostCfgPkg::cRegBase0, 32'h1000);
    expectReg("base1 readback", memPostCfgPkg::cRegBase1, 32'h2000);
    expectReg("words readback", memPostCfgPkg::cRegWords, 32'd4);
    expectReg("status idle", memPostCfgPkg::cRegStatus, 32'h0);
    writeReg(memPostCfgPkg::cRegBase1, 32'h2010);  // Not 64-byte aligned
    expectReg("status invalid", memPostCfgPkg::cRegStatus, 32'h8000_0000);
    writeReg(memPostCfgPkg::cRegCtrl, 32'd1);
    expectReg("ctrl readback", memPostCfgPkg::cRegCtrl, 32'd1);
    pulseStart();
    supplyWords(4);
    expectSilence("invalid setting", 100);
    expectReg("status held", memPostCfgPkg::cRegStatus, 32'h8000_0000);
    writeReg(memPostCfgPkg::cRegBase1, 32'h2000);
    checkPacket("first packet", 32'h1000, 4);

    // Address advance and ping-pong
    supplyWords(4);
    checkPacket("advance", 32'h1020, 4);
    curWords = 3;
    writeReg(memPostCfgPkg::cRegWords, 32'd3);
    supplyWords(3);
    checkPacket("odd words", 32'h1040, 3);
    pulseStart();
    supplyWords(3);
    checkPacket("other base", 32'h2000, 3);

    ////////////////////////////////////////////////////////////
    // Credit gating
    ////////////////////////////////////////////////////////////
    @(posedge w_Clk);
    credConPh <= 8'd20;  // Limit reached
    supplyWords(3);
    expectSilence("header credit", 100);
    expectReg("status busy", memPostCfgPkg::cRegStatus, 32'h1);
    @(posedge w_Clk);
    credLimPh <= 8'd21;
    checkPacket("credit release", 32'h2018, 3);
    @(posedge w_Clk);
    credConPh <= 8'd21;
    credConPd <= 12'd500;
    supplyWords(3);
    expectSilence("both credits", 60);
    @(posedge w_Clk);
    infPh <= 1'b1;
    infPd <= 1'b1;
    checkPacket("infinite credit", 32'h2030, 3);

    // Random back-pressure
    @(posedge w_Clk);
    randReady <= 1'b1;
    curWords = 8;
    writeReg(memPostCfgPkg::cRegWords, 32'd8);
    supplyWords(16);
    checkPacket("random ready 0", 32'h2048, 8);
    checkPacket("random ready 1", 32'h2088, 8);
    checkValue("leftover lines", 0, txQ.size());

    assertFails = DUT.uAssert.failCnt;
    $display("Closing: %0d value errors, %0d other errors, %0d assertion failures",
             valueErrs, otherErrs, assertFails);
    if (valueErrs + otherErrs + assertFails == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- memPost.f
memPostCfgPkg.sv
memPostTlpPkg.sv
memPostCfgRegs.sv
memPostScheduler.sv
memPostLineFifo.sv
memPostFramer.sv
memPostTop.sv
tbClkGen.sv
tbMemPost_assert.sv
tbMemPost.sv

//--- Makefile
# Verilator build and run of the memPost testbench

obj_dir/VtbMemPost: memPost.f $(shell cat memPost.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tbMemPost -f memPost.f

run: obj_dir/VtbMemPost
	obj_dir/VtbMemPost +verilator+error+limit+1000 > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Some tests failed" sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
